// ==== rtl/noc_pkg.sv ====
package noc_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    localparam int DATA_W    = 32;
    localparam int COORD_W   = 4;
    localparam int LEN_W     = 8;
    localparam int NUM_PORTS = 5;

    // bits left over in the head descriptor.
    localparam int RSVD_W = DATA_W - 4 * COORD_W - LEN_W;

    // --------------------------------------------------
    // flit format
    // --------------------------------------------------
    // head_tail is a packet without body words.
    typedef enum logic [1:0] {
        flit_head      = 2'd0,
        flit_body      = 2'd1,
        flit_tail      = 2'd2,
        flit_head_tail = 2'd3
    } flit_kind_e;

    // first word of a packet.
    typedef struct packed {
        logic [COORD_W-1:0] dest_x;
        logic [COORD_W-1:0] dest_y;
        logic [COORD_W-1:0] src_x;
        logic [COORD_W-1:0] src_y;
        logic [LEN_W-1:0]   len;
        logic [RSVD_W-1:0]  rsvd;
    } flit_head_t;

    // descriptor on a head flit, plain data otherwise.
    typedef union packed {
        flit_head_t        head;
        logic [DATA_W-1:0] data;
    } flit_payload_u;

    typedef struct packed {
        flit_kind_e    kind;
        flit_payload_u payload;
    } flit_t;

    // --------------------------------------------------
    // output ports
    // --------------------------------------------------
    // value doubles as the out_req / out_ack index.
    typedef enum logic [2:0] {
        port_north = 3'd0,
        port_south = 3'd1,
        port_east  = 3'd2,
        port_west  = 3'd3,
        port_local = 3'd4
    } port_e;

endpackage

// ==== rtl/flit_injector.sv ====
`timescale 1ns/100ps

module flit_injector #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_req,
    input  logic [noc_pkg::DATA_W-1:0] in_word,
    input  logic                       in_first,
    output logic                       in_ack,
    output logic                       push,
    output noc_pkg::flit_t             push_flit,
    input  logic                       credit
);

    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [CNT_W-1:0]          credit_cnt;
    logic [noc_pkg::LEN_W-1:0] body_left;
    noc_pkg::flit_payload_u    word_u;
    noc_pkg::flit_kind_e       next_kind;
    logic                      accept;

    // host word seen through the union.
    assign word_u.data = in_word;

    // new request, not yet acked, and room downstream.
    assign accept = in_req && !in_ack && (credit_cnt != '0);

    // --------------------------------------------------
    // packet framing
    // --------------------------------------------------
    always_comb begin
        if (in_first) begin
            if (word_u.head.len == '0) begin
                next_kind = noc_pkg::flit_head_tail;
            end else begin
                next_kind = noc_pkg::flit_head;
            end
        end else if (body_left <= 1) begin
            next_kind = noc_pkg::flit_tail;
        end else begin
            next_kind = noc_pkg::flit_body;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            body_left <= '0;
        end else if (accept) begin
            if (in_first) begin
                body_left <= word_u.head.len;
            end else if (body_left != '0) begin
                body_left <= body_left - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            push_flit.kind    <= next_kind;
            push_flit.payload <= word_u;
        end
    end

    // --------------------------------------------------
    // host handshake and credits
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_ack <= 1'b0;
            push   <= 1'b0;
        end else begin
            push <= accept;
            if (accept) begin
                in_ack <= 1'b1;
            end else if (!in_req) begin
                in_ack <= 1'b0;
            end
        end
    end

    // one credit per free buffer slot.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_cnt <= CNT_W'(FIFO_DEPTH);
        end else begin
            case ({accept, credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

endmodule

// ==== rtl/input_buffer.sv ====
`timescale 1ns/100ps

module input_buffer #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           push,
    input  noc_pkg::flit_t push_flit,
    input  logic           pop,
    output logic           head_valid,
    output noc_pkg::flit_t head_flit,
    output logic           credit
);

    // depth must be a power of two for the wrap bit scheme.
    localparam int AW = $clog2(FIFO_DEPTH);

    noc_pkg::flit_t mem [FIFO_DEPTH];

    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        full;
    logic        wr_en;
    logic        rd_en;

    // same slot, wrap bits differ.
    assign full = (wr_ptr[AW] != rd_ptr[AW]) &&
                  (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign head_valid = (wr_ptr != rd_ptr);
    assign head_flit  = mem[rd_ptr[AW-1:0]];

    assign wr_en = push && !full;
    assign rd_en = pop && head_valid;

    // --------------------------------------------------
    // storage
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= push_flit;
        end
    end

    // --------------------------------------------------
    // pointers and credit return
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            credit <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // slot freed, tell the injector.
            credit <= rd_en;
        end
    end

endmodule

// ==== rtl/route_unit.sv ====
`timescale 1ns/100ps

module route_unit #(
    parameter int ROUTER_X = 2,
    parameter int ROUTER_Y = 2
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          head_valid,
    input  noc_pkg::flit_t                head_flit,
    output logic                          pop,
    output noc_pkg::flit_t                out_flit,
    output logic [noc_pkg::NUM_PORTS-1:0] out_req,
    input  logic [noc_pkg::NUM_PORTS-1:0] out_ack
);

    localparam logic [noc_pkg::COORD_W-1:0] MY_X = ROUTER_X[noc_pkg::COORD_W-1:0];
    localparam logic [noc_pkg::COORD_W-1:0] MY_Y = ROUTER_Y[noc_pkg::COORD_W-1:0];

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_REQ     = 2'd1;
    localparam logic [1:0] ST_ACK_LOW = 2'd2;

    logic [1:0]     state;
    logic           locked;
    logic           issue;
    logic           last_flit;
    noc_pkg::port_e cur_port;
    noc_pkg::port_e yx_port;
    noc_pkg::port_e port_sel;

    // --------------------------------------------------
    // yx routing
    // --------------------------------------------------
    // y first, then x.
    always_comb begin
        if (head_flit.payload.head.dest_y > MY_Y) begin
            yx_port = noc_pkg::port_north;
        end else if (head_flit.payload.head.dest_y < MY_Y) begin
            yx_port = noc_pkg::port_south;
        end else if (head_flit.payload.head.dest_x > MY_X) begin
            yx_port = noc_pkg::port_east;
        end else if (head_flit.payload.head.dest_x < MY_X) begin
            yx_port = noc_pkg::port_west;
        end else begin
            yx_port = noc_pkg::port_local;
        end
    end

    // body and tail follow the locked port.
    assign port_sel = locked ? cur_port : yx_port;

    assign issue     = (state == ST_IDLE) && head_valid;
    assign last_flit = (out_flit.kind == noc_pkg::flit_tail) ||
                       (out_flit.kind == noc_pkg::flit_head_tail);

    // --------------------------------------------------
    // output handshake
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            out_req  <= '0;
            pop      <= 1'b0;
            locked   <= 1'b0;
            cur_port <= noc_pkg::port_local;
        end else begin
            pop <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (issue) begin
                        out_req           <= '0;
                        out_req[port_sel] <= 1'b1;
                        cur_port          <= port_sel;
                        if (head_flit.kind == noc_pkg::flit_head) begin
                            locked <= 1'b1;
                        end
                        state <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (out_ack[cur_port]) begin
                        out_req <= '0;
                        pop     <= 1'b1;
                        // tail done, port is free again.
                        if (last_flit) begin
                            locked <= 1'b0;
                        end
                        state <= ST_ACK_LOW;
                    end
                end
                ST_ACK_LOW: begin
                    if (!out_ack[cur_port]) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // held until the next issue, covers the ack fall.
    always_ff @(posedge clk) begin
        if (issue) begin
            out_flit <= head_flit;
        end
    end

endmodule

// ==== rtl/noc_router_top.sv ====
`timescale 1ns/100ps

module noc_router_top #(
    parameter int FIFO_DEPTH = 8,
    parameter int ROUTER_X   = 2,
    parameter int ROUTER_Y   = 2
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_req,
    input  logic [noc_pkg::DATA_W-1:0]    in_word,
    input  logic                          in_first,
    output logic                          in_ack,
    output noc_pkg::flit_t                out_flit,
    output logic [noc_pkg::NUM_PORTS-1:0] out_req,
    input  logic [noc_pkg::NUM_PORTS-1:0] out_ack
);

    logic           push;
    noc_pkg::flit_t push_flit;
    logic           credit;
    logic           head_valid;
    noc_pkg::flit_t head_flit;
    logic           pop;

    // --------------------------------------------------
    // producer, buffer, consumer
    // --------------------------------------------------
    flit_injector #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_injector (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_req     (in_req),
        .in_word    (in_word),
        .in_first   (in_first),
        .in_ack     (in_ack),
        .push       (push),
        .push_flit  (push_flit),
        .credit     (credit)
    );

    input_buffer #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_buffer (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (push),
        .push_flit  (push_flit),
        .pop        (pop),
        .head_valid (head_valid),
        .head_flit  (head_flit),
        .credit     (credit)
    );

    route_unit #(
        .ROUTER_X   (ROUTER_X),
        .ROUTER_Y   (ROUTER_Y)
    ) u_route (
        .clk        (clk),
        .rst_n      (rst_n),
        .head_valid (head_valid),
        .head_flit  (head_flit),
        .pop        (pop),
        .out_flit   (out_flit),
        .out_req    (out_req),
        .out_ack    (out_ack)
    );

endmodule

// ==== dv/noc_checker.sv ====
`timescale 1ns/100ps

module noc_checker #(
    parameter int NUM_PORTS = noc_pkg::NUM_PORTS
) (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 in_req,
    input logic                 in_ack,
    input noc_pkg::flit_t       out_flit,
    input logic [NUM_PORTS-1:0] out_req,
    input logic [NUM_PORTS-1:0] out_ack
);

    // read by the testbench at the end of the run.
    int fail_cnt;

    initial begin
        fail_cnt = 0;
    end

    // --------------------------------------------------
    // output handshake, per port
    // --------------------------------------------------
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        // request holds until the receiver answers.
        req_held: assert property (@(posedge clk) disable iff (!rst_n)
            out_req[p] && !out_ack[p] |=> out_req[p])
        else begin
            fail_cnt++;
            $error("out_req[%0d] fell before out_ack rose", p);
        end

        req_drop: assert property (@(posedge clk) disable iff (!rst_n)
            out_req[p] && out_ack[p] |=> !out_req[p])
        else begin
            fail_cnt++;
            $error("out_req[%0d] still high one cycle after out_ack", p);
        end

        // a new request starts only with the ack low.
        req_start: assert property (@(posedge clk) disable iff (!rst_n)
            $rose(out_req[p]) |-> !out_ack[p])
        else begin
            fail_cnt++;
            $error("out_req[%0d] rose while out_ack was still high", p);
        end
    end

    // flit frozen from request rise to ack fall.
    flit_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (|out_req) || (|out_ack) |=> $stable(out_flit))
    else begin
        fail_cnt++;
        $error("out_flit changed during a handshake");
    end

    one_req: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(out_req))
    else begin
        fail_cnt++;
        $error("more than one out_req bit high");
    end

    // --------------------------------------------------
    // host side and reset
    // --------------------------------------------------
    ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(in_ack) |-> $past(in_req))
    else begin
        fail_cnt++;
        $error("in_ack rose without in_req");
    end

    ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
        in_ack && !in_req |=> !in_ack)
    else begin
        fail_cnt++;
        $error("in_ack did not fall after in_req dropped");
    end

    rst_quiet: assert property (@(posedge clk)
        (!rst_n && $past(!rst_n)) || $rose(rst_n) |-> !in_ack && (out_req == '0))
    else begin
        fail_cnt++;
        $error("in_ack or out_req high during reset");
    end

    rst_after: assert property (@(posedge clk)
        $rose(rst_n) |=> !in_ack && (out_req == '0))
    else begin
        fail_cnt++;
        $error("in_ack or out_req high one cycle after reset");
    end

endmodule

bind noc_router_top noc_checker u_checker (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_req   (in_req),
    .in_ack   (in_ack),
    .out_flit (out_flit),
    .out_req  (out_req),
    .out_ack  (out_ack)
);

// ==== dv/noc_tb.sv ====
`timescale 1ns/100ps

module noc_tb;

    localparam int DEPTH  = 4;
    localparam int NODE_X = 2;
    localparam int NODE_Y = 2;
    localparam int NP     = noc_pkg::NUM_PORTS;

    // routing 10, framing 9, back-pressure 10, lock 7.
    localparam int TOTAL_FLITS = 10 + 9 + 10 + 7;
    localparam int CYCLE_LIMIT = TOTAL_FLITS * 40 + 200;

    logic           clk;
    logic           rst_n;
    logic           in_req;
    logic [31:0]    in_word;
    logic           in_first;
    logic           in_ack;
    noc_pkg::flit_t out_flit;
    logic [NP-1:0]  out_req;
    wire  [NP-1:0]  out_ack;

    noc_pkg::flit_t exp_flits [$];
    int             exp_ports [$];
    int             err_cnt;
    int             test_cnt;
    int             cycle_cnt;
    int             words_acked;
    bit             stall_mode;
    bit             hold_local;

    noc_router_top #(
        .FIFO_DEPTH (DEPTH),
        .ROUTER_X   (NODE_X),
        .ROUTER_Y   (NODE_Y)
    ) uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_req   (in_req),
        .in_word  (in_word),
        .in_first (in_first),
        .in_ack   (in_ack),
        .out_flit (out_flit),
        .out_req  (out_req),
        .out_ack  (out_ack)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    // inputs change and outputs are read 1 ns after the edge.
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // y first, then x.
    function automatic int yx_port(input int dx, input int dy);
        if (dy > NODE_Y) return int'(noc_pkg::port_north);
        if (dy < NODE_Y) return int'(noc_pkg::port_south);
        if (dx > NODE_X) return int'(noc_pkg::port_east);
        if (dx < NODE_X) return int'(noc_pkg::port_west);
        return int'(noc_pkg::port_local);
    endfunction

    // --------------------------------------------------
    // host model
    // --------------------------------------------------
    task automatic send_word(input logic [31:0] w, input logic first);
        in_word  = w;
        in_first = first;
        in_req   = 1'b1;
        step();
        while (!in_ack) step();
        words_acked++;
        in_req = 1'b0;
        step();
        while (in_ack) step();
    endtask

    task automatic send_packet(input int dx, input int dy, input int len);
        noc_pkg::flit_head_t hd;
        noc_pkg::flit_t      f;
        logic [31:0]         w;
        int                  port;
        hd        = '0;
        hd.dest_x = 4'(dx);
        hd.dest_y = 4'(dy);
        hd.src_x  = 4'(NODE_X);
        hd.src_y  = 4'(NODE_Y);
        hd.len    = 8'(len);
        port      = yx_port(dx, dy);
        f.kind         = (len == 0) ? noc_pkg::flit_head_tail : noc_pkg::flit_head;
        f.payload.head = hd;
        exp_flits.push_back(f);
        exp_ports.push_back(port);
        send_word(f.payload.data, 1'b1);
        for (int i = 1; i <= len; i++) begin
            w              = $urandom;
            f.kind         = (i == len) ? noc_pkg::flit_tail : noc_pkg::flit_body;
            f.payload.data = w;
            exp_flits.push_back(f);
            exp_ports.push_back(port);
            send_word(w, 1'b0);
        end
    endtask

    // --------------------------------------------------
    // receivers
    // --------------------------------------------------
    task automatic check_flit(input int p);
        noc_pkg::flit_t exp_f;
        int             exp_p;
        if (exp_flits.size() == 0) begin
            $display("unexpected flit %h on port %0d at %0t", out_flit, p, $time);
            err_cnt++;
        end else begin
            exp_f = exp_flits.pop_front();
            exp_p = exp_ports.pop_front();
            assert (out_flit === exp_f) else begin
                $display("** Error at %0t: out_flit expected %h, got %h",
                         $time, exp_f, out_flit);
                err_cnt++;
            end
            assert (p == exp_p) else begin
                $display("** Error at %0t: out_req port expected %0d, got %0d",
                         $time, exp_p, p);
                err_cnt++;
            end
        end
    endtask

    for (genvar p = 0; p < NP; p++) begin : g_rx
        logic ack_r;
        int   delay;

        assign out_ack[p] = ack_r;

        initial begin
            ack_r = 1'b0;
            forever begin
                step();
                if (rst_n && out_req[p]) begin
                    delay = stall_mode ? int'($urandom_range(6, 1)) : 1;
                    repeat (delay) step();
                    while (p == int'(noc_pkg::port_local) && hold_local) step();
                    check_flit(p);
                    ack_r = 1'b1;
                    while (out_req[p]) step();
                    // ack may linger after the request drops.
                    delay = stall_mode ? int'($urandom_range(3, 0)) : 0;
                    repeat (delay) step();
                    ack_r = 1'b0;
                end
            end
        end
    end

    task automatic drain();
        while (exp_flits.size() != 0) step();
        while (out_ack != '0) step();
    endtask

    task automatic end_test(input string name, input int errs_before);
        test_cnt++;
        $display("%-14s %s (%0d mismatches)", name,
                 (err_cnt == errs_before) ? "ok" : "with errors", err_cnt - errs_before);
    endtask

    // --------------------------------------------------
    // tests
    // --------------------------------------------------
    initial begin
        int errs;
        int chk_fails;
        void'($urandom(32'hca35));
        clk         = 1'b0;
        rst_n       = 1'b0;
        in_req      = 1'b0;
        in_word     = '0;
        in_first    = 1'b0;
        stall_mode  = 1'b0;
        hold_local  = 1'b0;
        err_cnt     = 0;
        test_cnt    = 0;
        cycle_cnt   = 0;
        words_acked = 0;
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (3) step();

        errs = err_cnt;
        send_packet(3, 3, 1);
        send_packet(1, 0, 1);
        send_packet(3, 2, 1);
        send_packet(1, 2, 1);
        send_packet(2, 2, 1);
        drain();
        end_test("yx_routing", errs);

        errs = err_cnt;
        send_packet(3, 2, 0);
        send_packet(2, 1, 1);
        send_packet(1, 2, 5);
        drain();
        end_test("framing", errs);

        // local port stalls, the host must block once credits are gone.
        errs        = err_cnt;
        words_acked = 0;
        hold_local  = 1'b1;
        fork
            send_packet(2, 2, 9);
        join_none
        repeat (40) step();
        assert (words_acked == DEPTH) else begin
            $display("** Error at %0t: words_acked expected %0d, got %0d",
                     $time, DEPTH, words_acked);
            err_cnt++;
        end
        assert (in_req && !in_ack) else begin
            $display("host handshake was not held off with no credits left at %0t", $time);
            err_cnt++;
        end
        hold_local = 1'b0;
        wait fork;
        drain();
        end_test("back_pressure", errs);

        errs       = err_cnt;
        stall_mode = 1'b1;
        send_packet(2, 4, 3);
        send_packet(0, 2, 2);
        drain();
        stall_mode = 1'b0;
        end_test("packet_lock", errs);

        repeat (5) step();
        chk_fails = uut.u_checker.fail_cnt;
        $display("%0d tests, %0d mismatches, %0d assertion failures",
                 test_cnt, err_cnt, chk_fails);
        if (err_cnt == 0 && chk_fails == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
rtl/noc_pkg.sv
rtl/flit_injector.sv
rtl/input_buffer.sv
rtl/route_unit.sv
rtl/noc_router_top.sv
dv/noc_checker.sv
dv/noc_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := noc_tb
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_ARGS  := +verilator+error+limit+1000
LOG       := sim.log
PASS_MSG  := Test completed successfully
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) $(SIM_ARGS) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
